//--- design/n64VideoPkg.sv
package n64VideoPkg;

  ////////////////////////////////////////////////////////////
  // Bus and component widths
  ////////////////////////////////////////////////////////////

  // N64 VD bus width, also the width of one input color
  localparam int colorWidthI = 7;
  // One component on the ADV712x data bus
  localparam int colorWidthO = 8;

  // Bit positions in the sync word (all active low)
  localparam int syncBitCsync = 0;
  localparam int syncBitHsync = 1;
  localparam int syncBitClamp = 2;
  localparam int syncBitVsync = 3;

  ////////////////////////////////////////////////////////////
  // Color conversion
  ////////////////////////////////////////////////////////////

  // Cycles from pixel in to pixel out in the converter
  localparam int convLatency = 2;

  // Coefficients scaled by 2^coefShift
  localparam int coefShift = 8;
  localparam int coefYr    = 77;
  localparam int coefYg    = 150;
  localparam int coefYb    = 29;
  localparam int coefPbR   = 43;
  localparam int coefPbG   = 85;
  localparam int coefPbB   = 128;
  localparam int coefPrR   = 128;
  localparam int coefPrG   = 107;
  localparam int coefPrB   = 21;

  // Mid code for Pb and Pr
  localparam int chromaOffset = 128;

  // 8 bit times 8 bit coefficient
  localparam int prodWidth = 16;
  // Signed sum of three products, with headroom
  localparam int sumWidth  = 18;

  // Active-low sync bits, laid out as in the sync word
  typedef logic [3:0] syncT;

  // One pixel; r, g, b carry Y, Pb, Pr in YPbPr mode
  typedef struct packed {
    logic [colorWidthO-1:0] r;
    logic [colorWidthO-1:0] g;
    logic [colorWidthO-1:0] b;
  } rgbT;

endpackage

//--- design/vidDelay.sv
module vidDelay #(
  parameter type payloadT = logic,
  parameter int  depth    = 2
) (
  input  logic    vClk_i,
  input  logic    rst_i,
  input  logic    valid_i,
  input  payloadT data_i,
  output logic    valid_o,
  output payloadT data_o
);

  // Payload stages, index 0 is the newest
  payloadT          dataPipe [depth];
  // Valid bit per stage
  logic [depth-1:0] validPipe;

  // Payload shifts every cycle
  always_ff @(posedge vClk_i) begin
    dataPipe[0] <= data_i;
    for (int i = 1; i < depth; i++) begin
      dataPipe[i] <= dataPipe[i-1];
    end
  end

  // Valid chain, cleared by reset
  always_ff @(posedge vClk_i) begin
    if (rst_i) begin
      validPipe <= '0;
    end else begin
      validPipe[0] <= valid_i;
      for (int i = 1; i < depth; i++) begin
        validPipe[i] <= validPipe[i-1];
      end
    end
  end

  assign valid_o = validPipe[depth-1];
  assign data_o  = dataPipe[depth-1];

  // Valid leaves exactly depth cycles after it entered
  assert property (@(posedge vClk_i) disable iff (rst_i)
    !$past(rst_i, depth) |-> valid_o == $past(valid_i, depth));

endmodule

//--- design/n64BusDemux.sv
module n64BusDemux (
  input  logic                               vClk_i,
  input  logic                               rst_i,
  input  logic                               nVDSync_i,
  input  logic [n64VideoPkg::colorWidthI-1:0] vd_i,
  output logic                               pxValid_o,
  output n64VideoPkg::rgbT                   pxRgb_o,
  output n64VideoPkg::syncT                  pxSync_o
);

  import n64VideoPkg::*;

  ////////////////////////////////////////////////////////////
  // Phase tracking
  ////////////////////////////////////////////////////////////

  // 0 idle, 1 expect R, 2 expect G, 3 expect B
  logic [2:0] phase;

  // Sync word of the pixel being collected
  syncT syncLatch;
  // R and G held until B arrives
  logic [colorWidthO-1:0] rColor;
  logic [colorWidthO-1:0] gColor;

  // 7 to 8 bit, top bit copied into the new LSB
  function automatic logic [colorWidthO-1:0] widen(input logic [colorWidthI-1:0] c);
    return {c, c[colorWidthI-1]};
  endfunction

  always_ff @(posedge vClk_i) begin
    if (rst_i) begin
      phase     <= '0;
      pxValid_o <= 1'b0;
    end else begin
      // Strobe lasts a single cycle
      pxValid_o <= 1'b0;
      if (!nVDSync_i) begin
        // Sync word restarts collection, a partial pixel is lost
        phase <= 3'd1;
      end else if (phase != 3'd0) begin
        if (phase == 3'd3) begin
          // B sample closes the pixel
          phase     <= 3'd0;
          pxValid_o <= 1'b1;
        end else begin
          phase <= phase + 3'd1;
        end
      end
      // Idle with nVDSync high, extra samples are ignored
    end
  end

  ////////////////////////////////////////////////////////////
  // Payload capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vClk_i) begin
    if (!nVDSync_i) begin
      syncLatch <= vd_i[syncBitVsync:syncBitCsync];
    end else begin
      case (phase)
        3'd1: rColor <= widen(vd_i);
        3'd2: gColor <= widen(vd_i);
        3'd3: begin
          // Output held until the next pixel completes
          pxRgb_o.r <= rColor;
          pxRgb_o.g <= gColor;
          pxRgb_o.b <= widen(vd_i);
          pxSync_o  <= syncLatch;
        end
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Counter never runs past the B phase
  assert property (@(posedge vClk_i) disable iff (rst_i) phase <= 3'd3);

  // One strobe per pixel, never back to back
  assert property (@(posedge vClk_i) disable iff (rst_i) pxValid_o |=> !pxValid_o);

endmodule

//--- design/colorConv.sv
module colorConv (
  input  logic              vClk_i,
  input  logic              rst_i,
  input  logic              yPbPrEn_i,
  input  logic              valid_i,
  input  n64VideoPkg::rgbT  rgb_i,
  input  n64VideoPkg::syncT sync_i,
  output logic              valid_o,
  output n64VideoPkg::rgbT  data_o,
  output n64VideoPkg::syncT sync_o
);

  import n64VideoPkg::*;

  // Stage 1 products
  logic [prodWidth-1:0] pYr, pYg, pYb;
  logic [prodWidth-1:0] pPbR, pPbG, pPbB;
  logic [prodWidth-1:0] pPrR, pPrG, pPrB;

  // Stage 2 sums, before the shift
  logic signed [sumWidth-1:0] sumY, sumPb, sumPr;

  // Converted pixel and mode per stage
  rgbT  yuvReg;
  logic modeS1, modeS2;

  // Bypass pixel and its valid
  rgbT  rgbDly;
  logic pxValidD;
  logic syncValidD;

  // Zero extend a product into the signed sum width
  function automatic logic signed [sumWidth-1:0] ext(input logic [prodWidth-1:0] p);
    return sumWidth'(p);
  endfunction

  // Clamp to 0..255
  function automatic logic [colorWidthO-1:0] sat(input logic signed [sumWidth-1:0] v);
    if (v < 0) begin
      return '0;
    end
    if (v > (2 ** colorWidthO) - 1) begin
      return '1;
    end
    return v[colorWidthO-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // Stage 1, nine products
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vClk_i) begin
    pYr    <= prodWidth'(rgb_i.r * coefYr);
    pYg    <= prodWidth'(rgb_i.g * coefYg);
    pYb    <= prodWidth'(rgb_i.b * coefYb);
    pPbR   <= prodWidth'(rgb_i.r * coefPbR);
    pPbG   <= prodWidth'(rgb_i.g * coefPbG);
    pPbB   <= prodWidth'(rgb_i.b * coefPbB);
    pPrR   <= prodWidth'(rgb_i.r * coefPrR);
    pPrG   <= prodWidth'(rgb_i.g * coefPrG);
    pPrB   <= prodWidth'(rgb_i.b * coefPrB);
    // Jumper level taken with the pixel
    modeS1 <= yPbPrEn_i;
  end

  ////////////////////////////////////////////////////////////
  // Stage 2, sum, floor shift, offset, clamp
  ////////////////////////////////////////////////////////////

  always_comb begin
    sumY  = ext(pYr) + ext(pYg) + ext(pYb);
    sumPb = ext(pPbB) - ext(pPbR) - ext(pPbG);
    sumPr = ext(pPrR) - ext(pPrG) - ext(pPrB);
  end

  always_ff @(posedge vClk_i) begin
    // Arithmetic shift gives floor division
    yuvReg.r <= sat(sumY >>> coefShift);
    yuvReg.g <= sat((sumPb >>> coefShift) + sumWidth'(chromaOffset));
    yuvReg.b <= sat((sumPr >>> coefShift) + sumWidth'(chromaOffset));
    modeS2   <= modeS1;
  end

  // RGB bypass, aligned with the matrix output
  vidDelay #(
    .payloadT (rgbT),
    .depth    (convLatency)
  ) rgbDelay_i (
    .vClk_i  (vClk_i),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .data_i  (rgb_i),
    .valid_o (pxValidD),
    .data_o  (rgbDly)
  );

  // Syncs pass through unchanged
  vidDelay #(
    .payloadT (syncT),
    .depth    (convLatency)
  ) syncDelay_i (
    .vClk_i  (vClk_i),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .data_i  (sync_i),
    .valid_o (syncValidD),
    .data_o  (sync_o)
  );

  // Output select by the delayed mode
  assign data_o  = modeS2 ? yuvReg : rgbDly;
  assign valid_o = pxValidD;

  // Pixel and sync paths stay in step
  assert property (@(posedge vClk_i) disable iff (rst_i) pxValidD == syncValidD);

endmodule

//--- design/adv712xOutStage.sv
module adv712xOutStage (
  input  logic                                 vClk_i,
  input  logic                                 rst_i,
  input  logic                                 useVgaHVSync_i,
  input  logic                                 valid_i,
  input  n64VideoPkg::rgbT                     data_i,
  input  n64VideoPkg::syncT                    sync_i,
  output logic [3*n64VideoPkg::colorWidthO-1:0] vd_o,
  output logic                                 nCsync_o,
  output logic                                 nHSyncOrF1_o,
  output logic                                 nVSyncOrF2_o,
  output logic                                 dataStrobe_o
);

  import n64VideoPkg::*;

  // Registered H and V sync of the current pixel
  logic nHSyncReg;
  logic nVSyncReg;

  ////////////////////////////////////////////////////////////
  // Load on valid, hold between pixels
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vClk_i) begin
    if (rst_i) begin
      // Bus quiet, syncs inactive
      vd_o         <= '0;
      nCsync_o     <= 1'b1;
      nHSyncReg    <= 1'b1;
      nVSyncReg    <= 1'b1;
      dataStrobe_o <= 1'b0;
    end else begin
      // Strobe marks new data on the bus
      dataStrobe_o <= valid_i;
      if (valid_i) begin
        // R/Y on top, B/Pr at the bottom
        vd_o      <= {data_i.r, data_i.g, data_i.b};
        nCsync_o  <= sync_i[syncBitCsync];
        nHSyncReg <= sync_i[syncBitHsync];
        nVSyncReg <= sync_i[syncBitVsync];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // VGA sync pins
  ////////////////////////////////////////////////////////////

  // Jumper off, pins parked high
  assign nHSyncOrF1_o = nHSyncReg | ~useVgaHVSync_i;
  assign nVSyncOrF2_o = nVSyncReg | ~useVgaHVSync_i;

  // First cycle out of reset has no strobe and a clear bus
  assert property (@(posedge vClk_i)
    $fell(rst_i) |-> !dataStrobe_o && vd_o == '0);

endmodule

//--- design/n64VideoDacTop.sv
module n64VideoDacTop (
  input  logic                                 vClk_i,
  input  logic                                 rst_i,
  input  logic                                 nVDSync_i,
  input  logic [n64VideoPkg::colorWidthI-1:0]   vd_i,
  input  logic                                 yPbPrEn_i,
  input  logic                                 useVgaHVSync_i,
  output logic [3*n64VideoPkg::colorWidthO-1:0] vd_o,
  output logic                                 nCsync_o,
  output logic                                 nHSyncOrF1_o,
  output logic                                 nVSyncOrF2_o,
  output logic                                 dataStrobe_o
);

  import n64VideoPkg::*;

  // Demux to converter
  logic pxValid;
  rgbT  pxRgb;
  syncT pxSync;

  // Converter to output stage
  logic convValid;
  rgbT  convData;
  syncT convSync;

  ////////////////////////////////////////////////////////////
  // Bus demux, 1 cycle after B
  ////////////////////////////////////////////////////////////

  n64BusDemux busDemux_i (
    .vClk_i    (vClk_i),
    .rst_i     (rst_i),
    .nVDSync_i (nVDSync_i),
    .vd_i      (vd_i),
    .pxValid_o (pxValid),
    .pxRgb_o   (pxRgb),
    .pxSync_o  (pxSync)
  );

  ////////////////////////////////////////////////////////////
  // RGB or YPbPr, 2 more cycles
  ////////////////////////////////////////////////////////////

  colorConv colorConv_i (
    .vClk_i    (vClk_i),
    .rst_i     (rst_i),
    .yPbPrEn_i (yPbPrEn_i),
    .valid_i   (pxValid),
    .rgb_i     (pxRgb),
    .sync_i    (pxSync),
    .valid_o   (convValid),
    .data_o    (convData),
    .sync_o    (convSync)
  );

  // DAC bus and sync pins, last cycle of the 4
  adv712xOutStage outStage_i (
    .vClk_i         (vClk_i),
    .rst_i          (rst_i),
    .useVgaHVSync_i (useVgaHVSync_i),
    .valid_i        (convValid),
    .data_i         (convData),
    .sync_i         (convSync),
    .vd_o           (vd_o),
    .nCsync_o       (nCsync_o),
    .nHSyncOrF1_o   (nHSyncOrF1_o),
    .nVSyncOrF2_o   (nVSyncOrF2_o),
    .dataStrobe_o   (dataStrobe_o)
  );

endmodule

//--- verif/tbClkGen.sv
module tbClkGen #(
  parameter int halfPeriod  = 2,
  parameter int resetCycles = 10
) (
  output logic clk_o,
  output logic rst_o
);

  // Free-running video clock, period 2*halfPeriod
  initial begin
    clk_o = 1'b0;
    forever #halfPeriod clk_o = ~clk_o;
  end

  // Reset high for the first resetCycles rising edges
  initial begin
    rst_o = 1'b1;
    repeat (resetCycles) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

//--- verif/n64VideoDacTb.sv
module n64VideoDacTb;

  import n64VideoPkg::*;

  logic vClk;
  logic rst;
  logic nVDSync;
  logic [colorWidthI-1:0] vdIn;
  logic yPbPrEn;
  logic useVga;
  logic [3*colorWidthO-1:0] vdOut;
  logic nCsync;
  logic nHSyncOrF1;
  logic nVSyncOrF2;
  logic dataStrobe;

  // Expected pixels and their sync words, oldest first
  rgbT  expPixQ[$];
  syncT expSyncQ[$];

  logic [15:0] lfsrState = 16'd42799;

  tbClkGen clkGen_i (.clk_o(vClk), .rst_o(rst));

  n64VideoDacTop dut_i (
    .vClk_i         (vClk),
    .rst_i          (rst),
    .nVDSync_i      (nVDSync),
    .vd_i           (vdIn),
    .yPbPrEn_i      (yPbPrEn),
    .useVgaHVSync_i (useVga),
    .vd_o           (vdOut),
    .nCsync_o       (nCsync),
    .nHSyncOrF1_o   (nHSyncOrF1),
    .nVSyncOrF2_o   (nVSyncOrF2),
    .dataStrobe_o   (dataStrobe)
  );

  ////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////

  // Right-shifting Galois form, x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit, LSB taken each step
  task automatic randBits(input int n, output logic [6:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[5:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  function automatic logic [7:0] clamp8(input int v);
    return (v < 0) ? 8'd0 : (v > 255) ? 8'd255 : v[7:0];
  endfunction

  // Widened RGB, or YPbPr with floor division by 256
  function automatic rgbT refPixel(input logic [6:0] r7, g7, b7, input logic ycc);
    int  r;
    int  g;
    int  b;
    rgbT px;
    r = int'({r7, r7[6]});
    g = int'({g7, g7[6]});
    b = int'({b7, b7[6]});
    if (ycc) begin
      px.r = clamp8((77 * r + 150 * g + 29 * b) >>> 8);
      px.g = clamp8(128 + ((128 * b - 43 * r - 85 * g) >>> 8));
      px.b = clamp8(128 + ((128 * r - 107 * g - 21 * b) >>> 8));
    end else begin
      px.r = r[7:0];
      px.g = g[7:0];
      px.b = b[7:0];
    end
    return px;
  endfunction

  // Pin view of a sync word, clamp has no pin and reads 1
  function automatic syncT refPins(input syncT s, input logic vga);
    syncT p;
    p = 4'hF;
    p[syncBitCsync] = s[syncBitCsync];
    if (vga) begin
      p[syncBitHsync] = s[syncBitHsync];
      p[syncBitVsync] = s[syncBitVsync];
    end
    return p;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic reportFailure(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkPixel(input rgbT expV, input rgbT actV);
    if (actV !== expV) begin
      reportFailure($sformatf("mismatch at time %0t: vd_o expected %h got %h",
                              $time, expV, actV));
    end
  endtask

  task automatic checkSyncs(input syncT expV, input syncT actV);
    if (actV !== expV) begin
      reportFailure($sformatf("mismatch at time %0t: sync pins expected %b got %b",
                              $time, expV, actV));
    end
  endtask

  // Outputs settle by the falling edge, bus and pins checked every cycle
  initial begin
    rgbT  lastPixel;
    syncT lastSync;
    syncT pins;
    lastPixel = '0;
    lastSync  = 4'hF;
    forever begin
      @(negedge vClk);
      if (!rst) begin
        if (dataStrobe) begin
          if (expPixQ.size() == 0) begin
            reportFailure("dataStrobe_o pulsed with no pixel expected");
          end else begin
            lastPixel = expPixQ.pop_front();
            lastSync  = expSyncQ.pop_front();
          end
        end
        pins = 4'hF;
        pins[syncBitCsync] = nCsync;
        pins[syncBitHsync] = nHSyncOrF1;
        pins[syncBitVsync] = nVSyncOrF2;
        // Between strobes the previous pixel is held
        checkPixel(lastPixel, rgbT'(vdOut));
        checkSyncs(refPins(lastSync, useVga), pins);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus stimulus
  ////////////////////////////////////////////////////////////

  task automatic driveWord(input logic nSync, input logic [6:0] word);
    @(posedge vClk);
    #1;
    nVDSync = nSync;
    vdIn    = word;
  endtask

  // Samples after B are ignored by the demux
  task automatic idleCycles(input int n);
    logic [6:0] w;
    repeat (n) begin
      randBits(7, w);
      driveWord(1'b1, w);
    end
  endtask

  // Sync word then R, G, B; colors below 3 aborts the pixel
  task automatic sendPixel(input syncT s, input logic [6:0] r, g, b,
                           input logic ycc, input int colors);
    logic [6:0] pad;
    randBits(3, pad);
    driveWord(1'b0, {pad[2:0], s});
    if (colors > 0) begin
      driveWord(1'b1, r);
      // Mode stays put until the converter takes this pixel
      yPbPrEn = ycc;
    end
    if (colors > 1) driveWord(1'b1, g);
    if (colors > 2) begin
      driveWord(1'b1, b);
      expPixQ.push_back(refPixel(r, g, b, ycc));
      expSyncQ.push_back(s);
    end
  endtask

  task automatic randomPixel(input logic ycc, input int colors, input logic withGap);
    logic [6:0] s;
    logic [6:0] r;
    logic [6:0] g;
    logic [6:0] b;
    logic [6:0] gap;
    randBits(4, s);
    randBits(7, r);
    randBits(7, g);
    randBits(7, b);
    sendPixel(syncT'(s[3:0]), r, g, b, ycc, colors);
    if (withGap) begin
      randBits(2, gap);
      idleCycles(int'(gap[1:0]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int         waitCount;
    logic [6:0] bits;
    nVDSync = 1'b1;
    vdIn    = '0;
    yPbPrEn = 1'b0;
    useVga  = 1'b0;
    waitCount = 0;
    do begin
      @(posedge vClk);
      waitCount++;
      if (waitCount > 100) reportFailure("reset was never released");
    end while (rst);

    // Idle bus, outputs stay at their reset levels
    idleCycles(20);

    // RGB mode, VGA pins parked high
    repeat (30) randomPixel(1'b0, 3, 1'b1);

    // YPbPr corners then random pixels
    for (int k = 0; k < 8; k++) begin
      randBits(4, bits);
      sendPixel(syncT'(bits[3:0]), k[0] ? 7'd127 : 7'd0, k[1] ? 7'd127 : 7'd0,
                k[2] ? 7'd127 : 7'd0, 1'b1, 3);
    end
    repeat (30) randomPixel(1'b1, 3, 1'b1);

    // VGA jumper and mode both random per pixel
    repeat (40) begin
      randBits(2, bits);
      useVga = bits[0];
      randomPixel(bits[1], 3, 1'b1);
    end

    // Early sync words drop the partial pixel
    useVga = 1'b1;
    for (int k = 0; k < 12; k++) begin
      randomPixel(k[0], k % 3, 1'b0);
      randomPixel(k[1], 3, 1'b0);
    end

    // Back-to-back pairs with the mode flipped
    repeat (10) begin
      randBits(1, bits);
      randomPixel(bits[0], 3, 1'b0);
      randomPixel(~bits[0], 3, 1'b0);
    end
    idleCycles(1);

    // Drain the pipeline, bounded wait
    waitCount = 0;
    while (expPixQ.size() != 0 && waitCount < 50) begin
      @(posedge vClk);
      waitCount++;
    end
    // Quiet tail catches stray strobes
    idleCycles(10);

    if (expPixQ.size() != 0) begin
      $display("timeout, expected pixels never came out");
      $display("TESTBENCH FAILED");
      $fatal(1, "pixels missing");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

//--- n64VideoDac.f
design/n64VideoPkg.sv
design/vidDelay.sv
design/n64BusDemux.sv
design/colorConv.sv
design/adv712xOutStage.sv
design/n64VideoDacTop.sv
verif/tbClkGen.sv
verif/n64VideoDacTb.sv

//--- Makefile
# Verilator build and run of the n64VideoDac testbench

VERILATOR ?= verilator
TOP       ?= n64VideoDacTb
FILELIST  ?= n64VideoDac.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
